// ==== bench/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_tb;

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_FLUSH,
        OP_POKE
    } op_t;

    // expected completion time of an entry
    typedef enum logic [1:0] {
        LAT_ANY,
        LAT_HIT,
        LAT_MISS
    } lat_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [31:0] alt;
        lat_t        lat;
    } entry_t;

    // A and B share index 4 with different tags
    localparam logic [31:0] ADDR_A = 32'h0000_1040;
    localparam logic [31:0] ADDR_B = 32'h0000_2040;
    localparam logic [31:0] ADDR_U = 32'h0000_3300;
    localparam logic [31:0] ADDR_L = 32'h0000_0a80;
    localparam logic [31:0] ADDR_C = 32'h0000_5120;
    localparam logic [31:0] ADDR_P = 32'h0000_6200;

    logic                clk;
    logic                rst;
    cache_pkg::cpu_req_t req;
    logic [31:0]         rdata;
    logic                busy;
    logic                done;

    entry_t      tests [$];
    logic [31:0] model [logic [31:0]];
    int          cycle_count;
    int          cycle_limit;

    cache_top dut_i (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .rdata (rdata),
        .busy  (busy),
        .done  (done)
    );

    always #50 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("no done after %0d cycles, controller stuck in %s",
                cycle_count, dut_i.fsm_i.state_q.name()));
        end
    end

    task automatic add_entry(input op_t op, input logic [31:0] addr,
                             input logic [31:0] alt, input lat_t lat);
        entry_t e;
        e.op   = op;
        e.addr = addr;
        e.alt  = alt;
        e.lat  = lat;
        tests.push_back(e);
    endtask

    task automatic build_table();
        add_entry(OP_READ, ADDR_U, '0, LAT_MISS);
        add_entry(OP_WRITE, ADDR_A, '0, LAT_MISS);
        add_entry(OP_READ, ADDR_A, '0, LAT_HIT);
        // dirty victim A is written back before B is fetched
        add_entry(OP_WRITE, ADDR_B, '0, LAT_MISS);
        add_entry(OP_READ, ADDR_A, '0, LAT_MISS);
        add_entry(OP_READ, ADDR_B, '0, LAT_MISS);
        add_entry(OP_WRITE, ADDR_L, '0, LAT_MISS);
        add_entry(OP_WRITE, ADDR_L + 32'd4, '0, LAT_HIT);
        add_entry(OP_WRITE, ADDR_L + 32'd8, '0, LAT_HIT);
        add_entry(OP_WRITE, ADDR_L + 32'd12, '0, LAT_HIT);
        add_entry(OP_READ, ADDR_L + 32'd8, '0, LAT_HIT);
        add_entry(OP_READ, ADDR_L, '0, LAT_HIT);
        add_entry(OP_READ, ADDR_L + 32'd12, '0, LAT_HIT);
        add_entry(OP_READ, ADDR_L + 32'd4, '0, LAT_HIT);
        add_entry(OP_WRITE, ADDR_C, '0, LAT_MISS);
        add_entry(OP_FLUSH, '0, '0, LAT_ANY);
        // every line is invalid after the flush
        add_entry(OP_READ, ADDR_A, '0, LAT_MISS);
        add_entry(OP_READ, ADDR_L + 32'd4, '0, LAT_MISS);
        add_entry(OP_READ, ADDR_C, '0, LAT_MISS);
        add_entry(OP_READ, ADDR_L + 32'd12, '0, LAT_HIT);
        add_entry(OP_POKE, ADDR_P, ADDR_L + 32'd4, LAT_MISS);
        add_entry(OP_READ, ADDR_L + 32'd4, '0, LAT_HIT);
        add_entry(OP_READ, ADDR_P, '0, LAT_HIT);
        add_entry(OP_FLUSH, '0, '0, LAT_ANY);
        add_entry(OP_READ, ADDR_B, '0, LAT_MISS);
        add_entry(OP_READ, ADDR_U, '0, LAT_MISS);
        add_entry(OP_READ, ADDR_L, '0, LAT_MISS);
        add_entry(OP_READ, ADDR_L + 32'd8, '0, LAT_HIT);
        add_entry(OP_READ, ADDR_P, '0, LAT_MISS);
    endtask

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [31:0] key;
        key = addr & 32'hffff_fffc;
        if (model.exists(key)) begin
            return model[key];
        end
        return 32'h0;
    endfunction

    task automatic drive_op(input op_t op, input logic [31:0] addr, input logic [31:0] wdata);
        req          = '0;
        req.read     = (op == OP_READ) || (op == OP_POKE);
        req.write    = (op == OP_WRITE);
        req.flush    = (op == OP_FLUSH);
        req.addr.raw = addr;
        req.wdata    = wdata;
    endtask

    task automatic run_entry(input entry_t e);
        logic [31:0] wdata;
        logic [31:0] exp;
        int          cycles;
        logic        got_done;
        wdata    = $urandom;
        cycles   = 0;
        got_done = 1'b0;
        @(posedge clk);
        #1;
        // the previous done pulse lasts one cycle only
        assert (done === 1'b0)
        else stop_with_failure($sformatf("CHECK FAILED done expected %h actual %h",
            1'b0, done));
        drive_op(e.op, e.addr, wdata);
        while (!got_done) begin
            @(posedge clk);
            #1;
            cycles   = cycles + 1;
            got_done = done;
            if (cycles == 1) begin
                req = '0;
            end
            if (!got_done) begin
                assert (busy === 1'b1)
                else stop_with_failure($sformatf("CHECK FAILED busy expected %h actual %h",
                    1'b1, busy));
            end
            if (e.op == OP_POKE && !got_done) begin
                if (cycles == 2) begin
                    // a write while busy leaves cache and model alone
                    drive_op(OP_WRITE, e.alt, ~wdata);
                end else if (cycles == 3) begin
                    req = '0;
                end
            end
        end
        assert (busy === 1'b0)
        else stop_with_failure($sformatf("CHECK FAILED busy expected %h actual %h",
            1'b0, busy));
        if (e.lat == LAT_HIT) begin
            assert (cycles == 2)
            else stop_with_failure($sformatf("CHECK FAILED done latency expected %h actual %h",
                32'd2, cycles));
        end else if (e.lat == LAT_MISS) begin
            assert (cycles > 2)
            else stop_with_failure($sformatf("access to %h completed as a hit, a miss was expected",
                e.addr));
        end
        if (e.op == OP_WRITE) begin
            model[e.addr & 32'hffff_fffc] = wdata;
        end else if (e.op == OP_READ || e.op == OP_POKE) begin
            exp = model_word(e.addr);
            assert (rdata === exp)
            else stop_with_failure($sformatf("CHECK FAILED rdata expected %h actual %h at %h",
                exp, rdata, e.addr));
        end
    endtask

    initial begin
        void'($urandom(32'hba36_c839));
        clk         = 1'b0;
        rst         = 1'b1;
        req         = '0;
        cycle_count = 0;
        build_table();
        // worst case per entry is a write-back plus a fetch or a flush with every line dirty
        cycle_limit = tests.size() * (2 * (`MEM_LATENCY + 2) + 4
                      + `CACHE_LINES * (`MEM_LATENCY + 2)) + 100;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (tests[i]) begin
            run_entry(tests[i]);
        end
        $display("No errors");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_store.sv
hdl/cache_fsm.sv
hdl/block_memory.sv
hdl/cache_top.sv
bench/cache_tb.sv

// ==== hdl/block_memory.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module block_memory (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::mem_req_t mem_req,
    output cache_pkg::mem_rsp_t mem_rsp
);

    localparam int BLK_AW = $clog2(`MEM_BLOCKS);
    localparam int CNT_W  = $clog2(`MEM_LATENCY + 1);

    logic [`BLOCK_W-1:0]    blocks [`MEM_BLOCKS];
    logic [`MEM_BLOCKS-1:0] written_q;
    logic [BLK_AW-1:0]      blk;
    logic [CNT_W-1:0]       cnt_q;
    logic [CNT_W-1:0]       cnt_next;
    logic                   rd_ack_q;
    logic                   wr_ack_q;
    logic                   ack;

    // block number from address bits above the offset
    assign blk      = mem_req.block_addr[`OFFSET_W +: BLK_AW];
    assign cnt_next = cnt_q + 1'b1;
    assign ack      = rd_ack_q || wr_ack_q;

    // latency counter restarts after every acknowledge
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q    <= '0;
            rd_ack_q <= 1'b0;
            wr_ack_q <= 1'b0;
        end else begin
            rd_ack_q <= 1'b0;
            wr_ack_q <= 1'b0;
            if (ack || !(mem_req.rd || mem_req.wr)) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_next;
                if (cnt_next == CNT_W'(`MEM_LATENCY)) begin
                    rd_ack_q <= mem_req.rd;
                    wr_ack_q <= mem_req.wr;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ack_q) begin
            blocks[blk] <= mem_req.wdata;
        end
    end

    // blocks never written since reset read as zero
    always_ff @(posedge clk) begin
        if (rst) begin
            written_q <= '0;
        end else if (wr_ack_q) begin
            written_q[blk] <= 1'b1;
        end
    end

    assign mem_rsp.rd_ack = rd_ack_q;
    assign mem_rsp.wr_ack = wr_ack_q;
    assign mem_rsp.rdata  = written_q[blk] ? blocks[blk] : '0;

    rd_ack_held: assert property (@(posedge clk) disable iff (rst) rd_ack_q |-> mem_req.rd);
    wr_ack_held: assert property (@(posedge clk) disable iff (rst) wr_ack_q |-> mem_req.wr);

endmodule

// ==== hdl/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cache geometry, direct mapped
`define CACHE_LINES 256
`define INDEX_W     8
`define TAG_W       20
`define OFFSET_W    4

// one line is four 32-bit words
`define BLOCK_W     128

// main memory model, 64 KB of 16-byte blocks
`define MEM_BLOCKS  4096

// cycles from a memory request to its acknowledge
`define MEM_LATENCY 4

`endif

// ==== hdl/cache_fsm.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::cpu_req_t   req,
    output logic [31:0]           rdata,
    output logic                  busy,
    output logic                  done,
    output logic [`INDEX_W-1:0]   lookup_index,
    input  cache_pkg::line_meta_t meta,
    input  logic [`BLOCK_W-1:0]   line_data,
    output logic                  word_we,
    output logic                  line_we,
    output logic                  inval,
    output logic [`INDEX_W-1:0]   upd_index,
    output logic [1:0]            upd_word,
    output logic [`TAG_W-1:0]     upd_tag,
    output logic                  upd_dirty,
    output logic [`BLOCK_W-1:0]   upd_data,
    output cache_pkg::mem_req_t   mem_req,
    input  cache_pkg::mem_rsp_t   mem_rsp
);

    cache_pkg::ctrl_state_t state_q;
    cache_pkg::ctrl_state_t state_d;
    cache_pkg::cpu_req_t    req_q;
    logic [31:0]            rdata_q;
    logic                   done_q;
    logic                   done_d;
    logic [8:0]             flush_idx_q;
    logic [8:0]             flush_idx_d;
    logic [8:0]             flush_next;
    logic [`INDEX_W-1:0]    cur_index;
    logic                   hit;
    logic                   victim_dirty;
    logic                   take_req;

    assign take_req = (state_q == cache_pkg::IDLE) && (req.read || req.write || req.flush);

    // flush walks its own counter, everything else uses the held address
    assign cur_index = (state_q == cache_pkg::FLUSH) ? flush_idx_q[`INDEX_W-1:0]
                                                     : req_q.addr.f.index;

    assign lookup_index = cur_index;
    assign upd_index    = cur_index;
    assign upd_word     = req_q.addr.f.word;
    assign upd_tag      = req_q.addr.f.tag;
    // fetched lines are always loaded clean
    assign upd_dirty    = 1'b0;
    // word writes pick their lane out of the replicated CPU word
    assign upd_data     = (state_q == cache_pkg::LOOKUP) ? {4{req_q.wdata}} : mem_rsp.rdata;

    assign hit          = meta.valid && (meta.tag == req_q.addr.f.tag);
    assign victim_dirty = meta.valid && meta.dirty;
    assign flush_next   = flush_idx_q + 9'd1;

    assign busy  = (state_q != cache_pkg::IDLE);
    assign done  = done_q;
    assign rdata = rdata_q;

    always_comb begin
        state_d            = state_q;
        flush_idx_d        = flush_idx_q;
        done_d             = 1'b0;
        word_we            = 1'b0;
        line_we            = 1'b0;
        inval              = 1'b0;
        mem_req.rd         = 1'b0;
        mem_req.wr         = 1'b0;
        mem_req.block_addr = {req_q.addr.f.tag, cur_index, {`OFFSET_W{1'b0}}};
        mem_req.wdata      = line_data;

        case (state_q)
            cache_pkg::IDLE: begin
                if (req.flush) begin
                    state_d     = cache_pkg::FLUSH;
                    flush_idx_d = '0;
                end else if (req.read || req.write) begin
                    state_d = cache_pkg::LOOKUP;
                end
            end

            cache_pkg::LOOKUP: begin
                if (hit) begin
                    // write wins over read when both were raised
                    word_we = req_q.write;
                    done_d  = 1'b1;
                    state_d = cache_pkg::IDLE;
                end else if (victim_dirty) begin
                    state_d = cache_pkg::WRITE_BACK;
                end else begin
                    state_d = cache_pkg::ALLOCATE;
                end
            end

            cache_pkg::WRITE_BACK: begin
                // victim address comes from the stored tag
                mem_req.wr         = 1'b1;
                mem_req.block_addr = {meta.tag, cur_index, {`OFFSET_W{1'b0}}};
                if (mem_rsp.wr_ack) begin
                    state_d = cache_pkg::ALLOCATE;
                end
            end

            cache_pkg::ALLOCATE: begin
                mem_req.rd = 1'b1;
                if (mem_rsp.rd_ack) begin
                    line_we = 1'b1;
                    state_d = cache_pkg::LOOKUP;
                end
            end

            cache_pkg::FLUSH: begin
                if (victim_dirty) begin
                    mem_req.wr         = 1'b1;
                    mem_req.block_addr = {meta.tag, cur_index, {`OFFSET_W{1'b0}}};
                end
                // clean lines take one cycle, dirty ones wait for the write
                if (!victim_dirty || mem_rsp.wr_ack) begin
                    inval       = 1'b1;
                    flush_idx_d = flush_next;
                    if (flush_next == 9'(`CACHE_LINES)) begin
                        done_d  = 1'b1;
                        state_d = cache_pkg::IDLE;
                    end
                end
            end

            default: begin
                state_d = cache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= cache_pkg::IDLE;
            done_q      <= 1'b0;
            flush_idx_q <= '0;
        end else begin
            state_q     <= state_d;
            done_q      <= done_d;
            flush_idx_q <= flush_idx_d;
        end
    end

    // request copy and read result
    always_ff @(posedge clk) begin
        if (take_req) begin
            req_q <= req;
        end
        if (state_q == cache_pkg::LOOKUP && hit && !req_q.write) begin
            rdata_q <= line_data[req_q.addr.f.word*32 +: 32];
        end
    end

    mem_rd_wr_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(mem_req.rd && mem_req.wr)
    );

    done_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    );

endmodule

// ==== hdl/cache_pkg.sv ====
`include "cache_defs.svh"

package cache_pkg;

    // address fields from the top bit down
    typedef struct packed {
        logic [`TAG_W-1:0]    tag;
        logic [`INDEX_W-1:0]  index;
        logic [1:0]           word;
        logic [`OFFSET_W-3:0] byte_off;
    } addr_fields_t;

    // the same address word seen raw or split into fields
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } cache_addr_t;

    typedef struct packed {
        logic        read;
        logic        write;
        logic        flush;
        cache_addr_t addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                rd;
        logic                wr;
        logic [31:0]         block_addr;
        logic [`BLOCK_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                rd_ack;
        logic                wr_ack;
        logic [`BLOCK_W-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic              valid;
        logic              dirty;
    } line_meta_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        ALLOCATE,
        FLUSH
    } ctrl_state_t;

endpackage

// ==== hdl/cache_store.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_store (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`INDEX_W-1:0]   lookup_index,
    output cache_pkg::line_meta_t meta,
    output logic [`BLOCK_W-1:0]   line_data,
    input  logic                  word_we,
    input  logic                  line_we,
    input  logic                  inval,
    input  logic [`INDEX_W-1:0]   upd_index,
    input  logic [1:0]            upd_word,
    input  logic [`TAG_W-1:0]     upd_tag,
    input  logic                  upd_dirty,
    input  logic [`BLOCK_W-1:0]   upd_data
);

    logic [`BLOCK_W-1:0]     data_mem [`CACHE_LINES];
    logic [`TAG_W-1:0]       tag_mem  [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;
    logic [`CACHE_LINES-1:0] dirty_q;

    // lookup port, no clock
    assign meta.tag   = tag_mem[lookup_index];
    assign meta.valid = valid_q[lookup_index];
    assign meta.dirty = dirty_q[lookup_index];
    assign line_data  = data_mem[lookup_index];

    // data and tag arrays
    always_ff @(posedge clk) begin
        if (line_we) begin
            data_mem[upd_index] <= upd_data;
            tag_mem[upd_index]  <= upd_tag;
        end else if (word_we) begin
            // word lane taken from the same lane of upd_data
            data_mem[upd_index][upd_word*32 +: 32] <= upd_data[upd_word*32 +: 32];
        end
    end

    // line state bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (line_we) begin
            valid_q[upd_index] <= 1'b1;
            dirty_q[upd_index] <= upd_dirty;
        end else if (word_we) begin
            dirty_q[upd_index] <= 1'b1;
        end else if (inval) begin
            valid_q[upd_index] <= 1'b0;
            dirty_q[upd_index] <= 1'b0;
        end
    end

    // the controller issues one kind of update per cycle
    upd_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({word_we, line_we, inval})
    );

endmodule

// ==== hdl/cache_top.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_top (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::cpu_req_t req,
    output logic [31:0]         rdata,
    output logic                busy,
    output logic                done
);

    logic [`INDEX_W-1:0]   lookup_index;
    cache_pkg::line_meta_t meta;
    logic [`BLOCK_W-1:0]   line_data;
    logic                  word_we;
    logic                  line_we;
    logic                  inval;
    logic [`INDEX_W-1:0]   upd_index;
    logic [1:0]            upd_word;
    logic [`TAG_W-1:0]     upd_tag;
    logic                  upd_dirty;
    logic [`BLOCK_W-1:0]   upd_data;
    cache_pkg::mem_req_t   mem_req;
    cache_pkg::mem_rsp_t   mem_rsp;

    cache_fsm fsm_i (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .rdata        (rdata),
        .busy         (busy),
        .done         (done),
        .lookup_index (lookup_index),
        .meta         (meta),
        .line_data    (line_data),
        .word_we      (word_we),
        .line_we      (line_we),
        .inval        (inval),
        .upd_index    (upd_index),
        .upd_word     (upd_word),
        .upd_tag      (upd_tag),
        .upd_dirty    (upd_dirty),
        .upd_data     (upd_data),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp)
    );

    cache_store store_i (
        .clk          (clk),
        .rst          (rst),
        .lookup_index (lookup_index),
        .meta         (meta),
        .line_data    (line_data),
        .word_we      (word_we),
        .line_we      (line_we),
        .inval        (inval),
        .upd_index    (upd_index),
        .upd_word     (upd_word),
        .upd_tag      (upd_tag),
        .upd_dirty    (upd_dirty),
        .upd_data     (upd_data)
    );

    block_memory mem_i (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module cache_tb \
    --Mdir obj_dir \
    -f filelist.f

# the simulator exits non-zero on a fatal error, tee keeps the log either way
./obj_dir/Vcache_tb 2>&1 | tee sim.log

if grep -q "^No errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
